// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: all run check clean

all: obj_dir/Vrom_subsystem_tb

obj_dir/Vrom_subsystem_tb: verilog.f $(SRCS)
	verilator --binary --timing -f verilog.f --top-module rom_subsystem_tb -o Vrom_subsystem_tb

run: obj_dir/Vrom_subsystem_tb
	./obj_dir/Vrom_subsystem_tb > sim.log
	cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi

check:
	@if grep -q "Test failures found" sim.log; then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== rtl/bank_arbiter.sv ====
module bank_arbiter
	import rom_pkg::*;
(
	input  logic     clk_sd,
	input  logic     rst_n,
	input  logic     wr0_req,
	input  logic     wr1_req,
	input  bank_wr_t wr0,
	input  bank_wr_t wr1,
	output logic     wr0_ack,
	output logic     wr1_ack,
	input  logic     rd0_valid,
	input  logic     rd1_valid,
	input  rd_req_t  rd0,
	input  rd_req_t  rd1,
	output logic     rd0_grant,
	output logic     rd1_grant,
	output rd_rsp_t  rsp0,
	output rd_rsp_t  rsp1
);

	bank_wr_t   wr [2];
	rd_req_t    rd [2];
	logic [1:0] wr_req;
	logic [1:0] wr_ack;
	logic [1:0] wr_pend;
	logic [1:0] rd_valid;
	logic [1:0] rd_grant;
	logic [1:0] rsp_valid;
	logic [1:0] rsp_tag [2];
	rom_word_u  q [2];

	assign wr[0]    = wr0;
	assign wr[1]    = wr1;
	assign rd[0]    = rd0;
	assign rd[1]    = rd1;
	assign wr_req   = {wr1_req, wr0_req};
	assign rd_valid = {rd1_valid, rd0_valid};

	// Writes always win and a denied read just waits
	assign wr_pend  = wr_req ^ wr_ack;
	assign rd_grant = rd_valid & ~wr_pend;

	assign wr0_ack   = wr_ack[0];
	assign wr1_ack   = wr_ack[1];
	assign rd0_grant = rd_grant[0];
	assign rd1_grant = rd_grant[1];

	assign rsp0 = '{valid: rsp_valid[0], tag: rsp_tag[0], data: q[0]};
	assign rsp1 = '{valid: rsp_valid[1], tag: rsp_tag[1], data: q[1]};

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n) begin
			wr_ack    <= 2'b00;
			rsp_valid <= 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (wr_pend[i])
					wr_ack[i] <= wr_req[i];
			end
			rsp_valid <= rd_grant;
		end
	end

	// Tag follows the bank's one-cycle read latency
	always_ff @(posedge clk_sd) begin
		for (int i = 0; i < 2; i++) begin
			if (rd_grant[i])
				rsp_tag[i] <= rd[i].tag;
		end
	end

	rom_bank #(.WORDS(BANK0_WORDS)) u_bank0 (
		.clk_sd (clk_sd),
		.we     (wr_pend[0]),
		.wa     (wr[0].addr),
		.ds     (wr[0].ds),
		.d      (wr[0].data),
		.re     (rd_grant[0]),
		.ra     (rd[0].addr),
		.q      (q[0])
	);

	rom_bank #(.WORDS(BANK1_WORDS)) u_bank1 (
		.clk_sd (clk_sd),
		.we     (wr_pend[1]),
		.wa     (wr[1].addr),
		.ds     (wr[1].ds),
		.d      (wr[1].data),
		.re     (rd_grant[1]),
		.ra     (rd[1].addr),
		.q      (q[1])
	);

endmodule

// ==== rtl/download_front.sv ====
module download_front
	import rom_pkg::*;
(
	input  logic       clk_sd,
	input  logic       rst_n,
	input  dl_stream_t dl,
	input  logic       status_reset,
	input  logic       button_reset,
	output logic       wr0_req,
	output logic       wr1_req,
	output bank_wr_t   wr0,
	output bank_wr_t   wr1,
	output logic       dl_core_wr,
	output dl_write_t  dl_core,
	output logic       downloading,
	output logic       core_reset
);

	logic        wr_last;
	logic        dl_last;
	logic        rom_loaded;
	logic        wr_rise;
	logic        in_gfx;
	logic [24:0] gfx_ofs;

	assign wr_rise = dl.download & dl.wr & ~wr_last;
	assign in_gfx  = (dl.addr >= GFX_BASE) && (dl.addr < GFX_END);
	assign gfx_ofs = dl.addr - GFX_BASE;

	// Core gets the low part of the image as it streams past
	assign dl_core_wr  = dl.download & dl.wr & (dl.addr < {8'd0, DL_LIMIT});
	assign dl_core     = '{addr: dl.addr[16:0], data: dl.data};
	assign downloading = dl.download;

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n) begin
			wr_last    <= 1'b0;
			dl_last    <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
			wr0_req    <= 1'b0;
			wr1_req    <= 1'b0;
		end else begin
			wr_last <= dl.wr;
			dl_last <= dl.download;
			if (dl_last && !dl.download)
				rom_loaded <= 1'b1;
			core_reset <= status_reset | button_reset | ~rom_loaded;
			if (wr_rise) begin
				wr0_req <= ~wr0_req;
				if (in_gfx)
					wr1_req <= ~wr1_req;
			end
		end
	end

	always_ff @(posedge clk_sd) begin
		if (wr_rise) begin
			wr0.addr <= dl.addr[16:1];
			wr0.ds   <= {dl.addr[0], ~dl.addr[0]};
			wr0.data <= {dl.data, dl.data};
		end
		// Upper 16 KB of tile data lands in the high byte
		if (wr_rise && in_gfx) begin
			wr1.addr <= {2'b00, gfx_ofs[13:0]};
			wr1.ds   <= {gfx_ofs[14], ~gfx_ofs[14]};
			wr1.data <= {dl.data, dl.data};
		end
	end

endmodule

// ==== rtl/fetch_return.sv ====
module fetch_return
	import rom_pkg::*;
(
	input  logic        clk_sd,
	input  logic        rst_n,
	input  logic        downloading,
	input  logic [14:0] cpu_addr,
	input  logic        cpu_req,
	output logic        cpu_ack,
	output logic [7:0]  cpu_q,
	input  logic [19:0] snd_addr,
	input  logic        snd_req,
	output logic        snd_ack,
	output logic [15:0] snd_q,
	input  logic [13:0] gfx_addr,
	input  logic        gfx_req,
	output logic        gfx_ack,
	output logic [15:0] gfx_q,
	output logic        rd0_valid,
	output logic        rd1_valid,
	output rd_req_t     rd0,
	output rd_req_t     rd1,
	input  logic        rd0_grant,
	input  logic        rd1_grant,
	input  rd_rsp_t     rsp0,
	input  rd_rsp_t     rsp1
);

	logic        cpu_busy;
	logic        snd_busy;
	logic        gfx_busy;
	logic        busy0;
	logic        busy1;
	logic [1:0]  ff_pipe;
	logic        cpu_a0;
	logic        cpu_new;
	logic        cpu_ff_start;
	logic        cpu_issue;
	logic        snd_issue;
	logic        gfx_issue;
	logic        cpu_rsp;
	logic        snd_rsp;
	logic        gfx_rsp;
	logic [18:0] snd_sum;

	assign snd_sum = snd_addr[19:1] + {3'b000, SND_WORD_OFS};

	assign cpu_new      = (cpu_req ^ cpu_ack) & ~cpu_busy;
	// CPU reads during a download answer 8'hFF and skip the bank
	assign cpu_ff_start = cpu_new & downloading;
	assign cpu_issue    = cpu_new & ~downloading & ~busy0;
	assign snd_issue    = (snd_req ^ snd_ack) & ~snd_busy & ~busy0 & ~cpu_issue;
	assign gfx_issue    = (gfx_req ^ gfx_ack) & ~gfx_busy & ~busy1;

	assign cpu_rsp = rsp0.valid && rsp0.tag == TAG_CPU;
	assign snd_rsp = rsp0.valid && rsp0.tag == TAG_SND;
	assign gfx_rsp = rsp1.valid && rsp1.tag == TAG_GFX;

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n) begin
			rd0_valid <= 1'b0;
			rd1_valid <= 1'b0;
			busy0     <= 1'b0;
			busy1     <= 1'b0;
			cpu_busy  <= 1'b0;
			snd_busy  <= 1'b0;
			gfx_busy  <= 1'b0;
			ff_pipe   <= 2'b00;
			cpu_ack   <= 1'b0;
			snd_ack   <= 1'b0;
			gfx_ack   <= 1'b0;
		end else begin
			ff_pipe <= {ff_pipe[0], cpu_ff_start};
			if (rd0_grant)
				rd0_valid <= 1'b0;
			if (rd1_grant)
				rd1_valid <= 1'b0;
			if (cpu_issue || snd_issue) begin
				rd0_valid <= 1'b1;
				busy0     <= 1'b1;
			end
			if (gfx_issue) begin
				rd1_valid <= 1'b1;
				busy1     <= 1'b1;
				gfx_busy  <= 1'b1;
			end
			if (cpu_issue || cpu_ff_start)
				cpu_busy <= 1'b1;
			if (snd_issue)
				snd_busy <= 1'b1;
			if (rsp0.valid)
				busy0 <= 1'b0;
			if (cpu_rsp || ff_pipe[1]) begin
				cpu_ack  <= cpu_req;
				cpu_busy <= 1'b0;
			end
			if (snd_rsp) begin
				snd_ack  <= snd_req;
				snd_busy <= 1'b0;
			end
			if (gfx_rsp) begin
				gfx_ack  <= gfx_req;
				gfx_busy <= 1'b0;
				busy1    <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sd) begin
		if (cpu_issue) begin
			rd0    <= '{addr: {2'b00, cpu_addr[14:1]}, tag: TAG_CPU};
			cpu_a0 <= cpu_addr[0];
		end else if (snd_issue) begin
			rd0 <= '{addr: snd_sum[15:0], tag: TAG_SND};
		end
		if (gfx_issue)
			rd1 <= '{addr: {2'b00, gfx_addr}, tag: TAG_GFX};
		if (cpu_rsp)
			cpu_q <= cpu_a0 ? rsp0.data.bytes.hi : rsp0.data.bytes.lo;
		else if (ff_pipe[1])
			cpu_q <= 8'hFF;
		if (snd_rsp)
			snd_q <= rsp0.data.word;
		if (gfx_rsp)
			gfx_q <= rsp1.data.word;
	end

endmodule

// ==== rtl/rom_bank.sv ====
module rom_bank
	import rom_pkg::*;
#(
	parameter int WORDS = 65536
) (
	input  logic        clk_sd,
	input  logic        we,
	input  logic [15:0] wa,
	input  logic [1:0]  ds,
	input  rom_word_u   d,
	input  logic        re,
	input  logic [15:0] ra,
	output rom_word_u   q
);

	logic [15:0]              mem [WORDS];
	logic [$clog2(WORDS)-1:0] wa_i;
	logic [$clog2(WORDS)-1:0] ra_i;

	assign wa_i = wa[$clog2(WORDS)-1:0];
	assign ra_i = ra[$clog2(WORDS)-1:0];

	always_ff @(posedge clk_sd) begin
		if (we) begin
			if (ds[0])
				mem[wa_i][7:0] <= d.bytes.lo;
			if (ds[1])
				mem[wa_i][15:8] <= d.bytes.hi;
		end
		if (re)
			q <= mem[ra_i];
	end

endmodule

// ==== rtl/rom_pkg.sv ====
package rom_pkg;

	// ROM image layout
	localparam logic [16:0] DL_LIMIT     = 17'h1C200;
	localparam logic [24:0] GFX_BASE     = 25'h0007000;
	localparam logic [24:0] GFX_END      = 25'h000F000;
	localparam logic [15:0] SND_WORD_OFS = 16'hE100;

	localparam int BANK0_WORDS = 65536;
	localparam int BANK1_WORDS = 16384;

	// Read client tags
	localparam logic [1:0] TAG_CPU = 2'd0;
	localparam logic [1:0] TAG_SND = 2'd1;
	localparam logic [1:0] TAG_GFX = 2'd2;

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_stream_t;

	typedef struct packed {
		logic [16:0] addr;
		logic [7:0]  data;
	} dl_write_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [1:0]  ds;
		logic [15:0] data;
	} bank_wr_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [1:0]  tag;
	} rd_req_t;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} rom_bytes_t;

	// Sound reads the whole word and the CPU picks one byte
	typedef union packed {
		logic [15:0] word;
		rom_bytes_t  bytes;
	} rom_word_u;

	typedef struct packed {
		logic       valid;
		logic [1:0] tag;
		rom_word_u  data;
	} rd_rsp_t;

endpackage

// ==== rtl/rom_subsystem.sv ====
module rom_subsystem
	import rom_pkg::*;
(
	input  logic        clk_sd,
	input  logic        rst_n,
	input  dl_stream_t  dl,
	input  logic        status_reset,
	input  logic        button_reset,
	output logic        core_reset,
	output logic        dl_core_wr,
	output dl_write_t   dl_core,
	input  logic [14:0] cpu_addr,
	input  logic        cpu_req,
	output logic        cpu_ack,
	output logic [7:0]  cpu_q,
	input  logic [19:0] snd_addr,
	input  logic        snd_req,
	output logic        snd_ack,
	output logic [15:0] snd_q,
	input  logic [13:0] gfx_addr,
	input  logic        gfx_req,
	output logic        gfx_ack,
	output logic [15:0] gfx_q
);

	logic     wr0_req;
	logic     wr1_req;
	bank_wr_t wr0;
	bank_wr_t wr1;
	logic     downloading;
	logic     rd0_valid;
	logic     rd1_valid;
	logic     rd0_grant;
	logic     rd1_grant;
	rd_req_t  rd0;
	rd_req_t  rd1;
	rd_rsp_t  rsp0;
	rd_rsp_t  rsp1;

	download_front u_download_front (
		.clk_sd       (clk_sd),
		.rst_n        (rst_n),
		.dl           (dl),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.wr0_req      (wr0_req),
		.wr1_req      (wr1_req),
		.wr0          (wr0),
		.wr1          (wr1),
		.dl_core_wr   (dl_core_wr),
		.dl_core      (dl_core),
		.downloading  (downloading),
		.core_reset   (core_reset)
	);

	// Writes are never denied, so the front end needs no write ack
	bank_arbiter u_bank_arbiter (
		.clk_sd    (clk_sd),
		.rst_n     (rst_n),
		.wr0_req   (wr0_req),
		.wr1_req   (wr1_req),
		.wr0       (wr0),
		.wr1       (wr1),
		.wr0_ack   (),
		.wr1_ack   (),
		.rd0_valid (rd0_valid),
		.rd1_valid (rd1_valid),
		.rd0       (rd0),
		.rd1       (rd1),
		.rd0_grant (rd0_grant),
		.rd1_grant (rd1_grant),
		.rsp0      (rsp0),
		.rsp1      (rsp1)
	);

	fetch_return u_fetch_return (
		.clk_sd      (clk_sd),
		.rst_n       (rst_n),
		.downloading (downloading),
		.cpu_addr    (cpu_addr),
		.cpu_req     (cpu_req),
		.cpu_ack     (cpu_ack),
		.cpu_q       (cpu_q),
		.snd_addr    (snd_addr),
		.snd_req     (snd_req),
		.snd_ack     (snd_ack),
		.snd_q       (snd_q),
		.gfx_addr    (gfx_addr),
		.gfx_req     (gfx_req),
		.gfx_ack     (gfx_ack),
		.gfx_q       (gfx_q),
		.rd0_valid   (rd0_valid),
		.rd1_valid   (rd1_valid),
		.rd0         (rd0),
		.rd1         (rd1),
		.rd0_grant   (rd0_grant),
		.rd1_grant   (rd1_grant),
		.rsp0        (rsp0),
		.rsp1        (rsp1)
	);

endmodule

// ==== verif/rom_subsystem_tb.sv ====
module rom_subsystem_tb
	import rom_pkg::*;
();

	logic        clk_sd;
	logic        rst_n;
	dl_stream_t  dl;
	logic        status_reset;
	logic        button_reset;
	logic        core_reset;
	logic        dl_core_wr;
	dl_write_t   dl_core;
	logic [14:0] cpu_addr;
	logic        cpu_req;
	logic        cpu_ack;
	logic [7:0]  cpu_q;
	logic [19:0] snd_addr;
	logic        snd_req;
	logic        snd_ack;
	logic [15:0] snd_q;
	logic [13:0] gfx_addr;
	logic        gfx_req;
	logic        gfx_ack;
	logic [15:0] gfx_q;

	int    errors;
	int    checks;
	int    tests;
	int    test_errors;
	string cur_test;

	tb_clock u_tb_clock (
		.clk_sd (clk_sd),
		.rst_n  (rst_n)
	);

	rom_subsystem u_rom_subsystem (
		.clk_sd       (clk_sd),
		.rst_n        (rst_n),
		.dl           (dl),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.core_reset   (core_reset),
		.dl_core_wr   (dl_core_wr),
		.dl_core      (dl_core),
		.cpu_addr     (cpu_addr),
		.cpu_req      (cpu_req),
		.cpu_ack      (cpu_ack),
		.cpu_q        (cpu_q),
		.snd_addr     (snd_addr),
		.snd_req      (snd_req),
		.snd_ack      (snd_ack),
		.snd_q        (snd_q),
		.gfx_addr     (gfx_addr),
		.gfx_req      (gfx_req),
		.gfx_ack      (gfx_ack),
		.gfx_q        (gfx_q)
	);

	// Image byte is the low address byte XOR the middle byte plus 5A
	function automatic logic [7:0] model_byte(input logic [24:0] a);
		return (a[7:0] ^ a[15:8]) + 8'h5A;
	endfunction

	// Lower 16 KB of tiles in the low byte and upper 16 KB in the high byte
	function automatic rom_word_u gfx_expect(input logic [13:0] w);
		rom_word_u r;
		r.bytes.lo = model_byte(GFX_BASE + 25'(w));
		r.bytes.hi = model_byte(GFX_BASE + 25'h4000 + 25'(w));
		return r;
	endfunction

	function automatic rom_word_u snd_expect(input logic [19:0] s);
		logic [15:0] k;
		rom_word_u   r;
		k = 16'(s[19:1] + 19'(SND_WORD_OFS));
		r.bytes.lo = model_byte({8'd0, k, 1'b0});
		r.bytes.hi = model_byte({8'd0, k, 1'b1});
		return r;
	endfunction

	function automatic bit acks_done(input bit on_cpu, input bit on_snd, input bit on_gfx);
		return (!on_cpu || cpu_ack == cpu_req) && (!on_snd || snd_ack == snd_req) &&
			(!on_gfx || gfx_ack == gfx_req);
	endfunction

	task automatic next_cycle();
		@(posedge clk_sd);
		#1;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (n < 20 && rst_n !== 1'b1) begin
			@(negedge clk_sd);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was not released within 20 cycles");
			errors++;
		end
		next_cycle();
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors == test_errors)
			$display("%s: passed", cur_test);
		else
			$display("%s: %0d errors", cur_test, errors - test_errors);
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s: %s expected %b actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string what, input rom_word_u exp, input rom_word_u act);
		checks++;
		if (act.word !== exp.word) begin
			$display("FAILED %s: %s expected %h actual %h", cur_test, what, exp.word, act.word);
			errors++;
		end
	endtask

	task automatic check_core_write(input dl_write_t exp, input dl_write_t act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s: dl_core expected %h/%h actual %h/%h", cur_test,
				exp.addr, exp.data, act.addr, act.data);
			errors++;
		end
	endtask

	task automatic wait_acks(input bit on_cpu, input bit on_snd, input bit on_gfx);
		int n;
		n = 0;
		while (n < 200 && !acks_done(on_cpu, on_snd, on_gfx)) begin
			next_cycle();
			n++;
		end
		if (!acks_done(on_cpu, on_snd, on_gfx)) begin
			$display("%s: read was not acknowledged within 200 cycles", cur_test);
			errors++;
		end
	endtask

	task automatic cpu_start(input logic [14:0] a);
		cpu_addr = a;
		cpu_req  = ~cpu_req;
	endtask

	task automatic snd_start(input logic [19:0] s);
		snd_addr = s;
		snd_req  = ~snd_req;
	endtask

	task automatic gfx_start(input logic [13:0] w);
		gfx_addr = w;
		gfx_req  = ~gfx_req;
	endtask

	// One strobe then three idle cycles per byte
	task automatic dl_bytes(input logic [24:0] start, input int len, input bit check_fwd);
		logic [24:0] a;
		dl_write_t   exp;
		for (int i = 0; i < len; i++) begin
			a           = start + 25'(i);
			dl.download = 1'b1;
			dl.addr     = a;
			dl.data     = model_byte(a);
			dl.wr       = 1'b1;
			if (check_fwd) begin
				@(negedge clk_sd);
				exp.addr = a[16:0];
				exp.data = model_byte(a);
				check_bit("dl_core_wr", a < 25'(DL_LIMIT), dl_core_wr);
				if (a < 25'(DL_LIMIT))
					check_core_write(exp, dl_core);
			end
			next_cycle();
			dl.wr = 1'b0;
			repeat (3) next_cycle();
		end
	endtask

	task automatic dl_finish();
		dl.download = 1'b0;
		dl.wr       = 1'b0;
		repeat (2) next_cycle();
	endtask

	task automatic test_reset_state();
		start_test("reset_state");
		check_bit("core_reset", 1'b1, core_reset);
		check_bit("cpu_ack", 1'b0, cpu_ack);
		check_bit("snd_ack", 1'b0, snd_ack);
		check_bit("gfx_ack", 1'b0, gfx_ack);
		check_bit("dl_core_wr", 1'b0, dl_core_wr);
		end_test();
	endtask

	task automatic test_download_forwarding();
		start_test("download_forwarding");
		// Straddles the forwarding limit
		dl_bytes(25'h1C1FC, 8, 1'b1);
		cpu_start(15'h0123);
		wait_acks(1'b1, 1'b0, 1'b0);
		check_byte("cpu_q during download", 8'hFF, cpu_q);
		end_test();
	endtask

	task automatic test_reset_release();
		start_test("reset_release");
		dl_finish();
		check_bit("core_reset after download", 1'b0, core_reset);
		status_reset = 1'b1;
		next_cycle();
		check_bit("core_reset on status_reset", 1'b1, core_reset);
		status_reset = 1'b0;
		next_cycle();
		check_bit("core_reset after status_reset", 1'b0, core_reset);
		button_reset = 1'b1;
		next_cycle();
		check_bit("core_reset on button_reset", 1'b1, core_reset);
		button_reset = 1'b0;
		next_cycle();
		check_bit("core_reset after button_reset", 1'b0, core_reset);
		end_test();
	endtask

	task automatic test_cpu_reads();
		logic [14:0] a;
		start_test("cpu_reads");
		dl_bytes(25'h0, 1024, 1'b0);
		dl_finish();
		for (int i = 0; i < 16; i++) begin
			a = 15'($urandom % 1024);
			cpu_start(a);
			wait_acks(1'b1, 1'b0, 1'b0);
			check_byte("cpu_q", model_byte(25'(a)), cpu_q);
		end
		end_test();
	endtask

	task automatic test_gfx_reads();
		logic [13:0] w;
		logic [14:0] a;
		start_test("gfx_reads");
		dl_bytes(25'h07000, 256, 1'b0);
		dl_bytes(25'h0B000, 256, 1'b0);
		dl_finish();
		for (int i = 0; i < 8; i++) begin
			w = 14'($urandom % 256);
			gfx_start(w);
			wait_acks(1'b0, 1'b0, 1'b1);
			check_word("gfx_q", gfx_expect(w), gfx_q);
		end
		for (int i = 0; i < 4; i++) begin
			w = 14'($urandom % 256);
			a = 15'($urandom % 1024);
			cpu_start(a);
			gfx_start(w);
			wait_acks(1'b1, 1'b0, 1'b1);
			check_byte("cpu_q with gfx", model_byte(25'(a)), cpu_q);
			check_word("gfx_q with cpu", gfx_expect(w), gfx_q);
		end
		end_test();
	endtask

	task automatic test_sound_reads();
		logic [19:0] s;
		logic [14:0] a;
		start_test("sound_reads");
		dl_bytes(25'h1C200, 256, 1'b0);
		dl_finish();
		for (int i = 0; i < 8; i++) begin
			s = 20'($urandom % 256);
			snd_start(s);
			wait_acks(1'b0, 1'b1, 1'b0);
			check_word("snd_q", snd_expect(s), snd_q);
		end
		// Both land on bank 0 in the same cycle
		for (int i = 0; i < 4; i++) begin
			s = 20'($urandom % 256);
			a = 15'($urandom % 1024);
			cpu_start(a);
			snd_start(s);
			wait_acks(1'b1, 1'b1, 1'b0);
			check_byte("cpu_q with sound", model_byte(25'(a)), cpu_q);
			check_word("snd_q with cpu", snd_expect(s), snd_q);
		end
		end_test();
	endtask

	initial begin
		void'($urandom(32'h541c_5f67));
		dl           = '0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		cpu_addr     = '0;
		cpu_req      = 1'b0;
		snd_addr     = '0;
		snd_req      = 1'b0;
		gfx_addr     = '0;
		gfx_req      = 1'b0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		wait_reset_release();
		test_reset_state();
		test_download_forwarding();
		test_reset_release();
		test_cpu_reads();
		test_gfx_reads();
		test_sound_reads();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock (
	output logic clk_sd,
	output logic rst_n
);

	initial begin
		clk_sd = 1'b0;
		forever #5 clk_sd = ~clk_sd;
	end

	// Reset held over three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_sd);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== verilog.f ====
rtl/rom_pkg.sv
rtl/rom_bank.sv
rtl/download_front.sv
rtl/bank_arbiter.sv
rtl/fetch_return.sv
rtl/rom_subsystem.sv
verif/tb_clock.sv
verif/rom_subsystem_tb.sv
